// File: verilog.f
src/agp32_isa_pkg.sv
src/agp32_pipe_pkg.sv
src/agp32_decode.sv
src/agp32_execute.sv
src/agp32_result.sv
src/agp32_core.sv
verif/agp32_checker.sv
verif/tb_agp32.sv

// File: run_verilator.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

build_log=build.log
sim_log=sim.log

verilator --binary --timing -sv -f verilog.f --top-module tb_agp32 -o sim_agp32 \
  > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "build failed"
  exit 1
fi

./obj_dir/sim_agp32 > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

if grep -qx "Test OK" "$sim_log"; then
  exit 0
else
  exit 1
fi

// File: verif/tb_agp32.sv
`timescale 1ns/1ps

module tb_agp32;

  localparam int N_PROGS = 4;
  localparam int N_RUNS = 2 * N_PROGS; // each program without and with stalls.
  localparam int WATCHDOG_CYCLES = N_RUNS * 40 * 4 + 100;

  logic                 clk;
  logic                 arst_n;
  agp32_isa_pkg::word_t inst_rdata;
  logic                 inst_ready;
  logic [1:0]           data_in;
  agp32_isa_pkg::word_t pc;
  logic [9:0]           data_out;

  logic [31:0]      rnd;
  logic             b0;
  logic             b1;
  int               cur_prog;
  logic             stall_mode;
  int               run_seq;
  int               seen_seq;
  logic             done;
  logic [19:0][9:0] exp_vals;
  int               exp_count;
  int               run_id;
  logic             got_all;
  int               runs_passed;
  int               runs_failed;

  logic [31:0] prog [4][32];
  int          plen [4];
  int          elen [4];
  int          eb [4][20]; // expected value is eb + ek * data_in.
  int          ek [4][20];

  agp32_core u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_rdata (inst_rdata),
    .inst_ready (inst_ready),
    .data_in    (data_in),
    .pc         (pc),
    .data_out   (data_out)
  );

  agp32_checker u_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .done        (done),
    .exp_vals    (exp_vals),
    .exp_count   (exp_count),
    .run_id      (run_id),
    .got_all     (got_all),
    .runs_passed (runs_passed),
    .runs_failed (runs_failed)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic next_bit();
    logic b;
    b = rnd[0];
    rnd = lfsr_step(rnd);
    return b;
  endfunction

  function automatic logic [31:0] instr(input logic [5:0] opc, input logic [3:0] fn,
                                         input logic wi, input logic [5:0] w,
                                         input logic ai, input logic [5:0] a,
                                         input logic bi, input logic [5:0] b);
    return {wi, w, 1'b0, ai, a, bi, b, fn, opc};
  endfunction

  function automatic logic [31:0] ldc(input logic [5:0] w, input logic neg,
                                       input logic [22:0] val);
    return {1'b1, w, 1'b1, neg, val};
  endfunction

  function automatic logic [31:0] out_imm(input logic [3:0] fn, input logic [5:0] a,
                                           input logic [5:0] b);
    return instr(agp32_isa_pkg::OPC_OUT, fn, 1'b0, 6'd9, 1'b1, a, 1'b1, b);
  endfunction

  function automatic logic [31:0] out_reg(input logic [5:0] r);
    return instr(agp32_isa_pkg::OPC_OUT, agp32_isa_pkg::FN_PASS_B, 1'b0, 6'd9,
                 1'b1, 6'd0, 1'b0, r);
  endfunction

  // base below zero means the word makes no output.
  task automatic step(input int p, input logic [31:0] w, input int k, input int base);
    prog[p][plen[p]] = w;
    plen[p]++;
    if (base >= 0) begin
      eb[p][elen[p]] = base;
      ek[p][elen[p]] = k;
      elen[p]++;
    end
  endtask

  task automatic build_programs();
    for (int p = 0; p < N_PROGS; p++) begin
      plen[p] = 0;
      elen[p] = 0;
    end
    step(0, out_imm(agp32_isa_pkg::FN_ADD, 6'd5, 6'd7), 0, 12);
    step(0, out_imm(agp32_isa_pkg::FN_SUB, 6'd3, 6'd10), 0, 1017);
    step(0, out_imm(agp32_isa_pkg::FN_INC, 6'd9, 6'd0), 0, 10);
    step(0, out_imm(agp32_isa_pkg::FN_OVERFLOW, 6'd5, 6'd5), 0, 0);
    step(0, out_imm(agp32_isa_pkg::FN_DEC, 6'd0, 6'd0), 0, 1023);
    step(0, out_imm(agp32_isa_pkg::FN_MUL_LO, 6'd7, 6'h3d), 0, 1003);
    step(0, out_imm(agp32_isa_pkg::FN_MUL_HI, 6'h3f, 6'h3f), 0, 1022);
    step(0, out_imm(agp32_isa_pkg::FN_AND, 6'd12, 6'd10), 0, 8);
    step(0, out_imm(agp32_isa_pkg::FN_OR, 6'd12, 6'd3), 0, 15);
    step(0, out_imm(agp32_isa_pkg::FN_XOR, 6'd12, 6'd10), 0, 6);
    step(0, out_imm(agp32_isa_pkg::FN_EQ, 6'd5, 6'd5), 0, 1);
    step(0, out_imm(agp32_isa_pkg::FN_ADDC, 6'd5, 6'd5), 0, 0);
    step(0, out_imm(agp32_isa_pkg::FN_LT_SIGNED, 6'h3f, 6'd1), 0, 1);
    step(0, out_imm(agp32_isa_pkg::FN_LT_UNSIGNED, 6'h3f, 6'd1), 0, 0);
    step(0, out_imm(agp32_isa_pkg::FN_PASS_B, 6'd0, 6'd17), 0, 17);
    step(0, out_imm(agp32_isa_pkg::FN_CARRY, 6'd5, 6'd5), 0, 0);
    // shift amounts come from negative immediates, only the low 5 bits count.
    step(1, ldc(6'd1, 1'b0, 23'h4002f1), 0, -1);
    step(1, ldc(6'd2, 1'b1, 23'd5), 0, -1);
    step(1, out_reg(6'd1), 0, 753);
    step(1, out_reg(6'd2), 0, 1019);
    step(1, instr(agp32_isa_pkg::OPC_SHIFT, 4'd0, 1'b0, 6'd3, 1'b0, 6'd1, 1'b1, 6'h22), 0, -1);
    step(1, out_reg(6'd3), 0, 964);
    step(1, instr(agp32_isa_pkg::OPC_SHIFT, 4'd1, 1'b0, 6'd3, 1'b0, 6'd1, 1'b1, 6'h23), 0, -1);
    step(1, out_reg(6'd3), 0, 94);
    step(1, instr(agp32_isa_pkg::OPC_SHIFT, 4'd2, 1'b0, 6'd3, 1'b0, 6'd2, 1'b1, 6'h21), 0, -1);
    step(1, out_reg(6'd3), 0, 1021);
    step(1, instr(agp32_isa_pkg::OPC_SHIFT, 4'd3, 1'b0, 6'd3, 1'b0, 6'd2, 1'b1, 6'h3c), 0, -1);
    step(1, out_reg(6'd3), 0, 959); // wrapped bits land in the low bits.
    // dependency chain starting from data_in.
    step(2, instr(agp32_isa_pkg::OPC_IN, 4'd0, 1'b0, 6'd1, 1'b1, 6'd0, 1'b1, 6'd0), 0, -1);
    step(2, instr(agp32_isa_pkg::OPC_ALU, 4'd0, 1'b0, 6'd2, 1'b0, 6'd1, 1'b1, 6'd8), 0, -1);
    step(2, instr(agp32_isa_pkg::OPC_ALU, 4'd0, 1'b0, 6'd3, 1'b0, 6'd2, 1'b0, 6'd1), 0, -1);
    step(2, instr(agp32_isa_pkg::OPC_OUT, 4'd0, 1'b0, 6'd4, 1'b0, 6'd3, 1'b1, 6'd4), 2, 12);
    step(2, instr(agp32_isa_pkg::OPC_OUT, 4'd0, 1'b0, 6'd5, 1'b0, 6'd4, 1'b0, 6'd2), 3, 20);
    step(2, instr(agp32_isa_pkg::OPC_OUT, 4'd2, 1'b0, 6'd6, 1'b0, 6'd5, 1'b0, 6'd5), 0, 0);
    // branches; the outputs of 9 to 14 sit in flushed slots.
    step(3, ldc(6'd1, 1'b0, 23'd3), 0, -1);
    step(3, instr(agp32_isa_pkg::OPC_JZ, 4'd0, 1'b1, 6'd12, 1'b0, 6'd1, 1'b1, 6'd0), 0, -1);
    step(3, out_imm(agp32_isa_pkg::FN_PASS_B, 6'd0, 6'd5), 0, 5);
    step(3, instr(agp32_isa_pkg::OPC_JNZ, 4'd0, 1'b1, 6'd12, 1'b0, 6'd1, 1'b1, 6'd0), 0, -1);
    step(3, out_imm(agp32_isa_pkg::FN_PASS_B, 6'd0, 6'd9), 0, -1);
    step(3, out_imm(agp32_isa_pkg::FN_PASS_B, 6'd0, 6'd10), 0, -1);
    step(3, instr(agp32_isa_pkg::OPC_JZ, 4'd2, 1'b1, 6'd12, 1'b0, 6'd1, 1'b0, 6'd1), 0, -1);
    step(3, out_imm(agp32_isa_pkg::FN_PASS_B, 6'd0, 6'd11), 0, -1);
    step(3, out_imm(agp32_isa_pkg::FN_PASS_B, 6'd0, 6'd12), 0, -1);
    step(3, instr(agp32_isa_pkg::OPC_JNZ, 4'd0, 1'b1, 6'd12, 1'b1, 6'd0, 1'b1, 6'd0), 0, -1);
    step(3, out_imm(agp32_isa_pkg::FN_PASS_B, 6'd0, 6'd6), 0, 6);
    step(3, instr(agp32_isa_pkg::OPC_JUMP, 4'd0, 1'b0, 6'd7, 1'b1, 6'd12, 1'b1, 6'd0), 0, -1);
    step(3, out_imm(agp32_isa_pkg::FN_PASS_B, 6'd0, 6'd13), 0, -1);
    step(3, out_imm(agp32_isa_pkg::FN_PASS_B, 6'd0, 6'd14), 0, -1);
    step(3, out_reg(6'd7), 0, 48); // link is 44 + 4.
  endtask

  // instruction supply, stalls and data_in on the falling edge.
  always @(negedge clk) begin
    if (run_seq != seen_seq) begin
      data_in[0] = next_bit();
      data_in[1] = next_bit();
      seen_seq = run_seq;
    end
    if (int'(pc >> 2) < plen[cur_prog]) begin
      inst_rdata = prog[cur_prog][pc[6:2]];
    end else begin
      inst_rdata = agp32_isa_pkg::NOP_INSTR;
    end
    if (stall_mode) begin
      b0 = next_bit();
      b1 = next_bit();
      inst_ready = b0 | b1; // low one cycle in four.
    end else begin
      inst_ready = 1'b1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int cyc;
    clk = 1'b0;
    arst_n = 1'b0;
    inst_rdata = agp32_isa_pkg::NOP_INSTR;
    inst_ready = 1'b1;
    data_in = '0;
    rnd = 32'hd1358ff2;
    cur_prog = 0;
    stall_mode = 1'b0;
    run_seq = 0;
    seen_seq = 0;
    done = 1'b0;
    exp_vals = '0;
    exp_count = 0;
    run_id = 0;
    build_programs();
    for (int r = 0; r < N_RUNS; r++) begin
      @(negedge clk);
      arst_n = 1'b0;
      @(posedge clk);
      cur_prog = r % N_PROGS;
      stall_mode = (r >= N_PROGS);
      run_id = r;
      run_seq++;
      repeat (9) @(negedge clk);
      @(posedge clk);
      exp_count = elen[cur_prog];
      for (int i = 0; i < 20; i++) begin
        exp_vals[i] = 10'(eb[cur_prog][i] + ek[cur_prog][i] * int'(data_in));
      end
      @(negedge clk);
      arst_n = 1'b1;
      cyc = 0;
      while (!got_all && cyc < 100) begin
        @(negedge clk);
        cyc++;
      end
      repeat (20) @(negedge clk); // catch late or extra outputs.
      done = 1'b1;
      @(negedge clk);
      done = 1'b0;
    end
    $display("%0d runs: %0d passed, %0d failed", N_RUNS, runs_passed, runs_failed);
    if (runs_failed == 0 && runs_passed == N_RUNS) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verif/agp32_checker.sv
`timescale 1ns/1ps

module agp32_checker (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             done,
  input  logic [19:0][9:0] exp_vals,
  input  int               exp_count,
  input  int               run_id,
  output logic             got_all,
  output int               runs_passed,
  output int               runs_failed
);

  logic [9:0] prev;
  int         idx;
  int         errs;

  assign got_all = (idx >= exp_count);

  initial begin
    prev = '0;
    idx = 0;
    errs = 0;
    runs_passed = 0;
    runs_failed = 0;
  end

  // data_out as it stood through the previous cycle.
  always @(posedge clk) begin
    if (!arst_n) begin
      prev = '0;
      idx = 0;
      errs = 0;
    end else if (done) begin
      if (idx < exp_count) begin
        $display("run %0d: only %0d of %0d outputs appeared", run_id, idx, exp_count);
        errs++;
      end
      if (errs == 0) begin
        runs_passed++;
        $display("run %0d passed, %0d outputs checked", run_id, exp_count);
      end else begin
        runs_failed++;
        $display("run %0d failed with %0d errors", run_id, errs);
      end
    end else if (tb_agp32.u_dut.data_out != prev) begin
      prev = tb_agp32.u_dut.data_out;
      if (idx >= exp_count) begin
        $display("run %0d: data_out changed to %0d after the last expected output",
                 run_id, prev);
        errs++;
      end else if (prev != exp_vals[idx]) begin
        $display("FAILED at %0t: run %0d output %0d is %0d, expected %0d",
                 $time, run_id, idx, prev, exp_vals[idx]);
        errs++;
      end
      idx++;
    end
  end

endmodule

// File: src/agp32_core.sv
`timescale 1ns/1ps

module agp32_core (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  agp32_isa_pkg::word_t                    inst_rdata,
  input  logic                                    inst_ready,
  input  logic [agp32_pipe_pkg::DATA_IN_W-1:0]    data_in,
  output agp32_isa_pkg::word_t                    pc,
  output logic [agp32_pipe_pkg::DATA_OUT_W-1:0]   data_out
);

  logic                      advance;
  agp32_pipe_pkg::ex_op_t    ex_op;
  agp32_pipe_pkg::wb_op_t    wb_op;
  agp32_pipe_pkg::redirect_t redirect;
  agp32_pipe_pkg::reg_wr_t   reg_wr;

  assign advance = inst_ready; // all stages move together.

  agp32_decode u_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .advance    (advance),
    .inst_rdata (inst_rdata),
    .redirect   (redirect),
    .reg_wr     (reg_wr),
    .pc         (pc),
    .ex_op      (ex_op)
  );

  agp32_execute u_execute (
    .clk      (clk),
    .arst_n   (arst_n),
    .advance  (advance),
    .ex_op    (ex_op),
    .reg_wr   (reg_wr),
    .wb_op    (wb_op),
    .redirect (redirect)
  );

  agp32_result u_result (
    .clk      (clk),
    .arst_n   (arst_n),
    .advance  (advance),
    .wb_op    (wb_op),
    .data_in  (data_in),
    .reg_wr   (reg_wr),
    .data_out (data_out)
  );

endmodule

// File: src/agp32_result.sv
`timescale 1ns/1ps

module agp32_result (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  logic                                    advance,
  input  agp32_pipe_pkg::wb_op_t                  wb_op,
  input  logic [agp32_pipe_pkg::DATA_IN_W-1:0]    data_in,
  output agp32_pipe_pkg::reg_wr_t                 reg_wr,
  output logic [agp32_pipe_pkg::DATA_OUT_W-1:0]   data_out
);

  agp32_pipe_pkg::wb_op_t q;
  agp32_isa_pkg::word_t   wr_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= agp32_pipe_pkg::WB_BUBBLE;
    end else if (advance) begin
      q <= wb_op;
    end
  end

  always_comb begin
    case (q.opc)
      agp32_isa_pkg::OPC_SHIFT: wr_data = q.shift_res;
      agp32_isa_pkg::OPC_IN:    wr_data = 32'(data_in);
      agp32_isa_pkg::OPC_JUMP:  wr_data = q.pc + agp32_pipe_pkg::PC_STEP; // link.
      agp32_isa_pkg::OPC_LOADC: wr_data = q.imm;
      default:                  wr_data = q.alu_res; // alu and out.
    endcase
  end

  // no write while stalled.
  assign reg_wr.en   = q.write_reg && advance;
  assign reg_wr.addr = q.addr_w;
  assign reg_wr.data = wr_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_out <= '0;
    end else if (advance && q.opc == agp32_isa_pkg::OPC_OUT) begin
      data_out <= q.alu_res[agp32_pipe_pkg::DATA_OUT_W-1:0];
    end
  end

endmodule

// File: src/agp32_execute.sv
`timescale 1ns/1ps

module agp32_execute (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      advance,
  input  agp32_pipe_pkg::ex_op_t    ex_op,
  input  agp32_pipe_pkg::reg_wr_t   reg_wr,
  output agp32_pipe_pkg::wb_op_t    wb_op,
  output agp32_pipe_pkg::redirect_t redirect
);

  agp32_pipe_pkg::ex_op_t q;
  agp32_isa_pkg::word_t   a;
  agp32_isa_pkg::word_t   b;
  agp32_isa_pkg::word_t   w;
  agp32_isa_pkg::word_t   in_1;
  agp32_isa_pkg::word_t   in_2;
  logic [63:0]            prod;
  logic [agp32_isa_pkg::SHAMT_BITS-1:0] shamt;
  agp32_isa_pkg::word_t   alu_res;
  agp32_isa_pkg::word_t   shift_res;

  // result-stage write overrides a stale register operand.
  function automatic agp32_isa_pkg::word_t fwd(
    input agp32_isa_pkg::word_t     d,
    input agp32_isa_pkg::reg_addr_t addr,
    input logic                     is_imm,
    input agp32_pipe_pkg::reg_wr_t  wr
  );
    return (!is_imm && wr.en && wr.addr == addr) ? wr.data : d;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= agp32_pipe_pkg::EX_BUBBLE;
    end else if (advance) begin
      q <= redirect.taken ? agp32_pipe_pkg::EX_BUBBLE : ex_op;
    end
  end

  assign a = fwd(q.data_a, q.addr_a, q.a_imm, reg_wr);
  assign b = fwd(q.data_b, q.addr_b, q.b_imm, reg_wr);
  assign w = fwd(q.data_w, q.addr_w, q.w_imm, reg_wr);

  always_comb begin
    in_1 = (q.opc == agp32_isa_pkg::OPC_JUMP) ? q.pc : a; // link target math.
    in_2 = (q.opc == agp32_isa_pkg::OPC_JUMP) ? a : b;
    prod = 64'(in_1) * 64'(in_2);
    case (q.func)
      agp32_isa_pkg::FN_ADD:         alu_res = in_1 + in_2;
      agp32_isa_pkg::FN_SUB:         alu_res = in_1 - in_2;
      agp32_isa_pkg::FN_INC:         alu_res = in_1 + 32'd1;
      agp32_isa_pkg::FN_DEC:         alu_res = in_1 - 32'd1;
      agp32_isa_pkg::FN_MUL_LO:      alu_res = prod[31:0];
      agp32_isa_pkg::FN_MUL_HI:      alu_res = prod[63:32];
      agp32_isa_pkg::FN_AND:         alu_res = in_1 & in_2;
      agp32_isa_pkg::FN_OR:          alu_res = in_1 | in_2;
      agp32_isa_pkg::FN_XOR:         alu_res = in_1 ^ in_2;
      agp32_isa_pkg::FN_EQ:          alu_res = {31'b0, in_1 == in_2};
      agp32_isa_pkg::FN_LT_SIGNED:   alu_res = {31'b0, $signed(in_1) < $signed(in_2)};
      agp32_isa_pkg::FN_LT_UNSIGNED: alu_res = {31'b0, in_1 < in_2};
      agp32_isa_pkg::FN_PASS_B:      alu_res = in_2;
      default:                       alu_res = '0; // no flags kept.
    endcase
  end

  always_comb begin
    shamt = b[agp32_isa_pkg::SHAMT_BITS-1:0];
    case (q.func[1:0])
      2'd0:    shift_res = a << shamt;
      2'd1:    shift_res = a >> shamt;
      2'd2:    shift_res = $signed(a) >>> shamt;
      default: shift_res = (a >> shamt) | (a << (6'd32 - shamt)); // rotate right.
    endcase
  end

  always_comb begin
    redirect.taken  = 1'b0;
    redirect.target = alu_res;
    case (q.opc)
      agp32_isa_pkg::OPC_JUMP: redirect.taken = 1'b1;
      agp32_isa_pkg::OPC_JZ: begin
        redirect.taken  = (alu_res == '0);
        redirect.target = q.pc + w;
      end
      agp32_isa_pkg::OPC_JNZ: begin
        redirect.taken  = (alu_res != '0);
        redirect.target = q.pc + w;
      end
      default: redirect.taken = 1'b0;
    endcase
  end

  always_comb begin
    wb_op.pc        = q.pc;
    wb_op.opc       = q.opc;
    wb_op.addr_w    = q.addr_w;
    wb_op.alu_res   = alu_res;
    wb_op.shift_res = shift_res;
    wb_op.imm       = q.imm;
    wb_op.write_reg = q.opc inside {agp32_isa_pkg::OPC_ALU, agp32_isa_pkg::OPC_SHIFT,
                                    agp32_isa_pkg::OPC_OUT, agp32_isa_pkg::OPC_IN,
                                    agp32_isa_pkg::OPC_JUMP, agp32_isa_pkg::OPC_LOADC};
  end

endmodule

// File: src/agp32_decode.sv
`timescale 1ns/1ps

module agp32_decode (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      advance,
  input  agp32_isa_pkg::word_t      inst_rdata,
  input  agp32_pipe_pkg::redirect_t redirect,
  input  agp32_pipe_pkg::reg_wr_t   reg_wr,
  output agp32_isa_pkg::word_t      pc,
  output agp32_pipe_pkg::ex_op_t    ex_op
);

  agp32_isa_pkg::instr_t    ir;
  agp32_isa_pkg::word_t     id_pc;
  agp32_isa_pkg::word_t     regs [agp32_isa_pkg::NUM_REGS];
  agp32_isa_pkg::opcode_e   opc;
  agp32_isa_pkg::alu_func_e func;
  agp32_isa_pkg::word_t     lc;
  agp32_isa_pkg::word_t     imm;

  // register read with bypass from the write in flight.
  function automatic agp32_isa_pkg::word_t operand(
    input logic                      use_imm,
    input agp32_isa_pkg::reg_addr_t  addr,
    input agp32_isa_pkg::word_t      rd,
    input agp32_pipe_pkg::reg_wr_t   wr
  );
    agp32_isa_pkg::word_t val;
    val = (wr.en && wr.addr == addr) ? wr.data : rd;
    if (use_imm) begin
      val = {{26{addr[5]}}, addr}; // sign-extended field.
    end
    return val;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
      ir <= agp32_isa_pkg::NOP_INSTR;
    end else if (advance) begin
      pc <= redirect.taken ? redirect.target : pc + agp32_pipe_pkg::PC_STEP;
      ir <= redirect.taken ? agp32_isa_pkg::NOP_INSTR : inst_rdata; // flush.
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      id_pc <= pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_wr.en) begin
      regs[reg_wr.addr] <= reg_wr.data;
    end
  end

  always_comb begin
    if (ir.loadc) begin
      opc = ir.w_imm ? agp32_isa_pkg::OPC_LOADC : agp32_isa_pkg::OPC_NOP;
    end else begin
      case (ir.opc)
        agp32_isa_pkg::OPC_JZ, agp32_isa_pkg::OPC_JNZ:
          opc = agp32_isa_pkg::opcode_e'(ir.opc);
        agp32_isa_pkg::OPC_ALU, agp32_isa_pkg::OPC_SHIFT, agp32_isa_pkg::OPC_OUT,
        agp32_isa_pkg::OPC_IN, agp32_isa_pkg::OPC_JUMP:
          opc = ir.w_imm ? agp32_isa_pkg::OPC_NOP : agp32_isa_pkg::opcode_e'(ir.opc);
        default: opc = agp32_isa_pkg::OPC_NOP; // illegal or dropped.
      endcase
    end

    case (opc)
      agp32_isa_pkg::OPC_ALU, agp32_isa_pkg::OPC_OUT, agp32_isa_pkg::OPC_JUMP,
      agp32_isa_pkg::OPC_JZ, agp32_isa_pkg::OPC_JNZ:
        func = agp32_isa_pkg::alu_func_e'(ir.func);
      agp32_isa_pkg::OPC_SHIFT:
        func = agp32_isa_pkg::alu_func_e'({2'b11, ir.func[1:0]});
      default: func = agp32_isa_pkg::FN_AND;
    endcase

    lc = {{(32 - agp32_isa_pkg::LOADC_BITS){1'b0}}, ir[agp32_isa_pkg::LOADC_BITS-1:0]};
    if (ir.w_imm && ir.loadc) begin
      imm = ir.a_imm ? -lc : lc; // bit 23 negates.
    end else begin
      imm = '0;
    end
  end

  always_comb begin
    ex_op.pc     = id_pc;
    ex_op.opc    = opc;
    ex_op.func   = func;
    ex_op.data_a = operand(ir.a_imm, ir.addr_a, regs[ir.addr_a], reg_wr);
    ex_op.data_b = operand(ir.b_imm, ir.addr_b, regs[ir.addr_b], reg_wr);
    ex_op.data_w = operand(ir.w_imm, ir.addr_w, regs[ir.addr_w], reg_wr);
    ex_op.addr_a = ir.addr_a;
    ex_op.addr_b = ir.addr_b;
    ex_op.addr_w = ir.addr_w;
    ex_op.a_imm  = ir.a_imm;
    ex_op.b_imm  = ir.b_imm;
    ex_op.w_imm  = ir.w_imm;
    ex_op.imm    = imm;
  end

endmodule

// File: src/agp32_pipe_pkg.sv
package agp32_pipe_pkg;

  localparam agp32_isa_pkg::word_t PC_STEP = 32'd4;
  localparam int DATA_IN_W = 2;
  localparam int DATA_OUT_W = 10;

  // decode to execute.
  typedef struct packed {
    agp32_isa_pkg::word_t     pc;
    agp32_isa_pkg::opcode_e   opc;
    agp32_isa_pkg::alu_func_e func;
    agp32_isa_pkg::word_t     data_a;
    agp32_isa_pkg::word_t     data_b;
    agp32_isa_pkg::word_t     data_w;
    agp32_isa_pkg::reg_addr_t addr_a;
    agp32_isa_pkg::reg_addr_t addr_b;
    agp32_isa_pkg::reg_addr_t addr_w;
    logic                     a_imm;
    logic                     b_imm;
    logic                     w_imm;
    agp32_isa_pkg::word_t     imm;
  } ex_op_t;

  // execute to result.
  typedef struct packed {
    agp32_isa_pkg::word_t     pc;
    agp32_isa_pkg::opcode_e   opc;
    agp32_isa_pkg::reg_addr_t addr_w;
    agp32_isa_pkg::word_t     alu_res;
    agp32_isa_pkg::word_t     shift_res;
    agp32_isa_pkg::word_t     imm;
    logic                     write_reg;
  } wb_op_t;

  typedef struct packed {
    logic                     en;
    agp32_isa_pkg::reg_addr_t addr;
    agp32_isa_pkg::word_t     data;
  } reg_wr_t;

  typedef struct packed {
    logic                 taken;
    agp32_isa_pkg::word_t target;
  } redirect_t;

  localparam ex_op_t EX_BUBBLE = '{opc: agp32_isa_pkg::OPC_NOP,
                                   func: agp32_isa_pkg::FN_AND, default: '0};
  localparam wb_op_t WB_BUBBLE = '{opc: agp32_isa_pkg::OPC_NOP, default: '0};

endpackage

// File: src/agp32_isa_pkg.sv
package agp32_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [5:0] reg_addr_t;

  localparam int NUM_REGS = 64;
  localparam int LOADC_BITS = 23; // constant field of loadc.
  localparam int SHAMT_BITS = 5;

  typedef enum logic [5:0] {
    OPC_ALU   = 6'd0,
    OPC_SHIFT = 6'd1,
    OPC_OUT   = 6'd6,
    OPC_IN    = 6'd7,
    OPC_JUMP  = 6'd9,
    OPC_JZ    = 6'd10,
    OPC_JNZ   = 6'd11,
    OPC_LOADC = 6'd13,
    OPC_NOP   = 6'd15
  } opcode_e;

  typedef enum logic [3:0] {
    FN_ADD, FN_ADDC, FN_SUB, FN_CARRY,
    FN_OVERFLOW, FN_INC, FN_DEC, FN_MUL_LO,
    FN_MUL_HI, FN_AND, FN_OR, FN_XOR,
    FN_EQ, FN_LT_SIGNED, FN_LT_UNSIGNED, FN_PASS_B
  } alu_func_e;

  // instruction word, msb first.
  typedef struct packed {
    logic        w_imm;
    reg_addr_t   addr_w;
    logic        loadc;
    logic        a_imm;
    reg_addr_t   addr_a;
    logic        b_imm;
    reg_addr_t   addr_b;
    logic [3:0]  func;
    logic [5:0]  opc;
  } instr_t;

  localparam word_t NOP_INSTR = 32'd63; // opcode 63 decodes as nop.

endpackage
